//--- design/memPkg.sv
package memPkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int CNT_W  = 8;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [DATA_W-1:0] dataT;
  typedef logic [CNT_W-1:0]  cntT;

  // One write toward the RAM
  typedef struct packed {
    addrT addr;
    dataT data;
  } storeReqT;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } ctrlStateT;

  // Round-robin pick, first requester at or after ptr, -1 if none
  function automatic int rrPick(input logic [31:0] req, input int ptr, input int n);
    int idx;
    int pick;
    pick = -1;
    for (int k = 31; k >= 0; k--) begin
      if (k < n) begin
        idx = ptr + k;
        if (idx >= n) begin
          idx = idx - n;
        end
        if (req[idx]) begin
          pick = idx;
        end
      end
    end
    return pick;
  endfunction

endpackage

//--- design/storeController.sv
module storeController #(
  parameter int NUM_CONTROLS = 1,
  parameter int NUM_STORES   = 2
) (
  input  logic                                clk,
  input  logic                                rstN,
  // Start and end tokens
  input  logic                                memStartValid,
  output logic                                memStartReady,
  output logic                                memEndValid,
  input  logic                                memEndReady,
  input  logic                                ctrlEndValid,
  output logic                                ctrlEndReady,
  // Store counts per basic block
  input  memPkg::cntT  [NUM_CONTROLS-1:0]     ctrl,
  input  logic         [NUM_CONTROLS-1:0]     ctrlValid,
  output logic         [NUM_CONTROLS-1:0]     ctrlReady,
  // Store ports
  input  memPkg::addrT [NUM_STORES-1:0]       stAddr,
  input  logic         [NUM_STORES-1:0]       stAddrValid,
  output logic         [NUM_STORES-1:0]       stAddrReady,
  input  memPkg::dataT [NUM_STORES-1:0]       stData,
  input  logic         [NUM_STORES-1:0]       stDataValid,
  output logic         [NUM_STORES-1:0]       stDataReady,
  // Toward the RAM write port
  output memPkg::storeReqT                    storeReq,
  output logic                                storeReqValid,
  input  logic                                storeReqReady
);
  import memPkg::*;

  localparam int IDX_W  = (NUM_STORES > 1) ? $clog2(NUM_STORES) : 1;
  // Headroom for counts from many blocks before they drain
  localparam int PEND_W = CNT_W + 8;

  ctrlStateT         state;
  ctrlStateT         stateNext;
  logic [PEND_W-1:0] pending;
  logic [PEND_W-1:0] pendingNext;
  logic [PEND_W-1:0] ctrlSum;
  logic [NUM_STORES-1:0] storeCand;
  logic [IDX_W-1:0]  rrPtr;
  logic [IDX_W-1:0]  grantIdx;
  int                storePick;
  logic              storeEn;
  logic              storeFire;
  logic              ctrlEndFire;

  assign memStartReady = (state == IDLE);
  assign memEndValid   = (state == DONE);
  assign ctrlEndReady  = (state == RUN);
  assign ctrlReady     = {NUM_CONTROLS{state == RUN}};
  assign ctrlEndFire   = ctrlEndValid && ctrlEndReady;

  always_comb begin
    ctrlSum = '0;
    for (int c = 0; c < NUM_CONTROLS; c++) begin
      if (ctrlValid[c] && ctrlReady[c]) begin
        ctrlSum = ctrlSum + PEND_W'(ctrl[c]);
      end
    end
  end

  // Never issue past the announced count
  assign storeEn   = ((state == RUN) || (state == DRAIN)) && (pending != '0);
  assign storeCand = stAddrValid & stDataValid;

  always_comb begin
    storePick = rrPick(32'(storeCand), int'(rrPtr), NUM_STORES);
  end

  assign grantIdx      = IDX_W'(storePick);
  assign storeReqValid = storeEn && (storePick >= 0);
  assign storeFire     = storeReqValid && storeReqReady;
  assign storeReq      = storeReqT'{addr: stAddr[grantIdx], data: stData[grantIdx]};

  always_comb begin
    stAddrReady = '0;
    if (storeFire) begin
      stAddrReady[grantIdx] = 1'b1;
    end
  end

  assign stDataReady = stAddrReady;
  assign pendingNext = pending + ctrlSum - PEND_W'(storeFire);

  always_comb begin
    stateNext = state;
    unique case (state)
      IDLE: begin
        if (memStartValid) begin
          stateNext = RUN;
        end
      end
      RUN: begin
        if (ctrlEndFire) begin
          stateNext = (pendingNext == '0) ? DONE : DRAIN;
        end
      end
      DRAIN: begin
        if (pendingNext == '0) begin
          stateNext = DONE;
        end
      end
      DONE: begin
        if (memEndReady) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= IDLE;
      pending <= '0;
      rrPtr   <= '0;
    end else begin
      state <= stateNext;
      if ((state == DONE) && memEndReady) begin
        pending <= '0;
      end else begin
        pending <= pendingNext;
      end
      if (storeFire) begin
        rrPtr <= IDX_W'((storePick + 1) % NUM_STORES);
      end
    end
  end

endmodule

//--- design/readArbiter.sv
module readArbiter #(
  parameter int NUM_LOADS = 2,
  parameter int INFLIGHT  = 4
) (
  input  logic                             clk,
  input  logic                             rstN,
  // Load ports
  input  memPkg::addrT [NUM_LOADS-1:0]     ldAddr,
  input  logic         [NUM_LOADS-1:0]     ldAddrValid,
  output logic         [NUM_LOADS-1:0]     ldAddrReady,
  output memPkg::dataT [NUM_LOADS-1:0]     ldData,
  output logic         [NUM_LOADS-1:0]     ldDataValid,
  input  logic         [NUM_LOADS-1:0]     ldDataReady,
  // Toward the RAM read port
  output memPkg::addrT                     loadAddr,
  output logic                             loadAddrValid,
  input  logic                             loadAddrReady,
  input  memPkg::dataT                     loadData,
  input  logic                             loadDataValid,
  output logic                             loadDataReady
);
  import memPkg::*;

  localparam int IDX_W  = (NUM_LOADS > 1) ? $clog2(NUM_LOADS) : 1;
  localparam int PTR_W  = (INFLIGHT > 1) ? $clog2(INFLIGHT) : 1;
  localparam int QCNT_W = $clog2(INFLIGHT + 1);

  // Port index of every read on its way through the RAM
  logic [IDX_W-1:0]     idQueue [INFLIGHT];
  logic [PTR_W-1:0]     wrPtr;
  logic [PTR_W-1:0]     rdPtr;
  logic [QCNT_W-1:0]    qCount;
  logic [NUM_LOADS-1:0] inFlight;
  logic [NUM_LOADS-1:0] loadCand;
  logic [IDX_W-1:0]     rrPtr;
  logic [IDX_W-1:0]     grantIdx;
  logic [IDX_W-1:0]     retIdx;
  int                   loadPick;
  logic                 canIssue;
  logic                 grant;
  logic                 retire;

  assign canIssue = (qCount != QCNT_W'(INFLIGHT)) && (!loadAddrValid || loadAddrReady);
  // One word per port, held or on its way
  assign loadCand = ldAddrValid & ~inFlight & ~ldDataValid;

  always_comb begin
    loadPick = rrPick(32'(loadCand), int'(rrPtr), NUM_LOADS);
  end

  assign grant    = canIssue && (loadPick >= 0);
  assign grantIdx = IDX_W'(loadPick);

  always_comb begin
    ldAddrReady = '0;
    if (grant) begin
      ldAddrReady[grantIdx] = 1'b1;
    end
  end

  // Every in-flight read already owns its port register
  assign loadDataReady = 1'b1;
  assign retire        = loadDataValid && loadDataReady;
  assign retIdx        = idQueue[rdPtr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      loadAddrValid <= 1'b0;
    end else if (grant) begin
      loadAddrValid <= 1'b1;
    end else if (loadAddrReady) begin
      loadAddrValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      loadAddr         <= ldAddr[grantIdx];
      idQueue[wrPtr]   <= grantIdx;
    end
    if (retire) begin
      ldData[retIdx] <= loadData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      qCount <= '0;
      rrPtr  <= '0;
    end else begin
      if (grant) begin
        wrPtr <= (wrPtr == PTR_W'(INFLIGHT - 1)) ? '0 : wrPtr + 1'b1;
        rrPtr <= IDX_W'((loadPick + 1) % NUM_LOADS);
      end
      if (retire) begin
        rdPtr <= (rdPtr == PTR_W'(INFLIGHT - 1)) ? '0 : rdPtr + 1'b1;
      end
      qCount <= qCount + QCNT_W'(grant) - QCNT_W'(retire);
    end
  end

  // Per-port in-flight flag and output register valid
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inFlight    <= '0;
      ldDataValid <= '0;
    end else begin
      for (int p = 0; p < NUM_LOADS; p++) begin
        if (grant && (grantIdx == IDX_W'(p))) begin
          inFlight[p] <= 1'b1;
        end else if (retire && (retIdx == IDX_W'(p))) begin
          inFlight[p] <= 1'b0;
        end
        if (retire && (retIdx == IDX_W'(p))) begin
          ldDataValid[p] <= 1'b1;
        end else if (ldDataReady[p]) begin
          ldDataValid[p] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- design/memController.sv
module memController #(
  parameter int NUM_LOADS    = 2,
  parameter int NUM_STORES   = 2,
  parameter int NUM_CONTROLS = 1,
  parameter int INFLIGHT     = 4
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             memStartValid,
  output logic                             memStartReady,
  output logic                             memEndValid,
  input  logic                             memEndReady,
  input  logic                             ctrlEndValid,
  output logic                             ctrlEndReady,
  input  memPkg::cntT  [NUM_CONTROLS-1:0]  ctrl,
  input  logic         [NUM_CONTROLS-1:0]  ctrlValid,
  output logic         [NUM_CONTROLS-1:0]  ctrlReady,
  input  memPkg::addrT [NUM_LOADS-1:0]     ldAddr,
  input  logic         [NUM_LOADS-1:0]     ldAddrValid,
  output logic         [NUM_LOADS-1:0]     ldAddrReady,
  output memPkg::dataT [NUM_LOADS-1:0]     ldData,
  output logic         [NUM_LOADS-1:0]     ldDataValid,
  input  logic         [NUM_LOADS-1:0]     ldDataReady,
  input  memPkg::addrT [NUM_STORES-1:0]    stAddr,
  input  logic         [NUM_STORES-1:0]    stAddrValid,
  output logic         [NUM_STORES-1:0]    stAddrReady,
  input  memPkg::dataT [NUM_STORES-1:0]    stData,
  input  logic         [NUM_STORES-1:0]    stDataValid,
  output logic         [NUM_STORES-1:0]    stDataReady,
  // Dual-port RAM side
  output memPkg::addrT                     loadAddr,
  output logic                             loadAddrValid,
  input  logic                             loadAddrReady,
  input  memPkg::dataT                     loadData,
  input  logic                             loadDataValid,
  output logic                             loadDataReady,
  output memPkg::storeReqT                 storeReq,
  output logic                             storeReqValid,
  input  logic                             storeReqReady
);

  storeController #(
    .NUM_CONTROLS(NUM_CONTROLS),
    .NUM_STORES  (NUM_STORES)
  ) stores (
    .clk          (clk),
    .rstN         (rstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .storeReq     (storeReq),
    .storeReqValid(storeReqValid),
    .storeReqReady(storeReqReady)
  );

  readArbiter #(
    .NUM_LOADS(NUM_LOADS),
    .INFLIGHT (INFLIGHT)
  ) reads (
    .clk          (clk),
    .rstN         (rstN),
    .ldAddr       (ldAddr),
    .ldAddrValid  (ldAddrValid),
    .ldAddrReady  (ldAddrReady),
    .ldData       (ldData),
    .ldDataValid  (ldDataValid),
    .ldDataReady  (ldDataReady),
    .loadAddr     (loadAddr),
    .loadAddrValid(loadAddrValid),
    .loadAddrReady(loadAddrReady),
    .loadData     (loadData),
    .loadDataValid(loadDataValid),
    .loadDataReady(loadDataReady)
  );

endmodule

//--- design/dualPortRam.sv
module dualPortRam (
  input  logic             clk,
  input  logic             rstN,
  // Read port
  input  memPkg::addrT     loadAddr,
  input  logic             loadAddrValid,
  output logic             loadAddrReady,
  output memPkg::dataT     loadData,
  output logic             loadDataValid,
  // Write port
  input  memPkg::storeReqT storeReq,
  input  logic             storeReqValid,
  output logic             storeReqReady
);
  import memPkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  dataT mem [DEPTH];

  // Neither port ever stalls
  assign loadAddrReady = 1'b1;
  assign storeReqReady = 1'b1;

  always_ff @(posedge clk) begin
    if (storeReqValid) begin
      mem[storeReq.addr] <= storeReq.data;
    end
  end

  // Same-address read and write in one cycle returns the old word
  always_ff @(posedge clk) begin
    if (loadAddrValid) begin
      loadData <= mem[loadAddr];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      loadDataValid <= 1'b0;
    end else begin
      loadDataValid <= loadAddrValid && loadAddrReady;
    end
  end

endmodule

//--- design/memSys.sv
module memSys #(
  parameter int NUM_LOADS    = 2,
  parameter int NUM_STORES   = 2,
  parameter int NUM_CONTROLS = 1,
  parameter int INFLIGHT     = 4
) (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             memStartValid,
  output logic                             memStartReady,
  output logic                             memEndValid,
  input  logic                             memEndReady,
  input  logic                             ctrlEndValid,
  output logic                             ctrlEndReady,
  input  memPkg::cntT  [NUM_CONTROLS-1:0]  ctrl,
  input  logic         [NUM_CONTROLS-1:0]  ctrlValid,
  output logic         [NUM_CONTROLS-1:0]  ctrlReady,
  input  memPkg::addrT [NUM_LOADS-1:0]     ldAddr,
  input  logic         [NUM_LOADS-1:0]     ldAddrValid,
  output logic         [NUM_LOADS-1:0]     ldAddrReady,
  output memPkg::dataT [NUM_LOADS-1:0]     ldData,
  output logic         [NUM_LOADS-1:0]     ldDataValid,
  input  logic         [NUM_LOADS-1:0]     ldDataReady,
  input  memPkg::addrT [NUM_STORES-1:0]    stAddr,
  input  logic         [NUM_STORES-1:0]    stAddrValid,
  output logic         [NUM_STORES-1:0]    stAddrReady,
  input  memPkg::dataT [NUM_STORES-1:0]    stData,
  input  logic         [NUM_STORES-1:0]    stDataValid,
  output logic         [NUM_STORES-1:0]    stDataReady
);
  import memPkg::*;

  addrT     loadAddr;
  logic     loadAddrValid;
  logic     loadAddrReady;
  dataT     loadData;
  logic     loadDataValid;
  storeReqT storeReq;
  logic     storeReqValid;
  logic     storeReqReady;

  memController #(
    .NUM_LOADS   (NUM_LOADS),
    .NUM_STORES  (NUM_STORES),
    .NUM_CONTROLS(NUM_CONTROLS),
    .INFLIGHT    (INFLIGHT)
  ) u_ctrl (
    .clk          (clk),
    .rstN         (rstN),
    .memStartValid(memStartValid),
    .memStartReady(memStartReady),
    .memEndValid  (memEndValid),
    .memEndReady  (memEndReady),
    .ctrlEndValid (ctrlEndValid),
    .ctrlEndReady (ctrlEndReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .ldAddr       (ldAddr),
    .ldAddrValid  (ldAddrValid),
    .ldAddrReady  (ldAddrReady),
    .ldData       (ldData),
    .ldDataValid  (ldDataValid),
    .ldDataReady  (ldDataReady),
    .stAddr       (stAddr),
    .stAddrValid  (stAddrValid),
    .stAddrReady  (stAddrReady),
    .stData       (stData),
    .stDataValid  (stDataValid),
    .stDataReady  (stDataReady),
    .loadAddr     (loadAddr),
    .loadAddrValid(loadAddrValid),
    .loadAddrReady(loadAddrReady),
    .loadData     (loadData),
    .loadDataValid(loadDataValid),
    // RAM read data has no back-pressure input
    .loadDataReady(),
    .storeReq     (storeReq),
    .storeReqValid(storeReqValid),
    .storeReqReady(storeReqReady)
  );

  dualPortRam u_ram (
    .clk          (clk),
    .rstN         (rstN),
    .loadAddr     (loadAddr),
    .loadAddrValid(loadAddrValid),
    .loadAddrReady(loadAddrReady),
    .loadData     (loadData),
    .loadDataValid(loadDataValid),
    .storeReq     (storeReq),
    .storeReqValid(storeReqValid),
    .storeReqReady(storeReqReady)
  );

endmodule

//--- verif/clkGen.sv
module clkGen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk = ~clk;
    end
  end

endmodule

//--- verif/memSysProperties.sv_properties.sv
module memSysProperties #(
  parameter int NUM_LOADS    = 2,
  parameter int NUM_CONTROLS = 1
) (
  input logic                             clk,
  input logic                             rstN,
  input logic                             memStartReady,
  input logic                             memEndValid,
  input logic                             memEndReady,
  input memPkg::cntT  [NUM_CONTROLS-1:0]  ctrl,
  input logic         [NUM_CONTROLS-1:0]  ctrlValid,
  input logic         [NUM_CONTROLS-1:0]  ctrlReady,
  input memPkg::dataT [NUM_LOADS-1:0]     ldData,
  input logic         [NUM_LOADS-1:0]     ldDataValid,
  input logic         [NUM_LOADS-1:0]     ldDataReady,
  input logic                             loadAddrValid,
  input logic                             loadAddrReady,
  input logic                             loadDataValid,
  input logic                             storeReqValid,
  input logic                             storeReqReady
);

  // Stores announced but not yet written
  int pend;
  int ctrlSum;

  always_comb begin
    ctrlSum = 0;
    for (int c = 0; c < NUM_CONTROLS; c++) begin
      if (ctrlValid[c] && ctrlReady[c]) begin
        ctrlSum = ctrlSum + int'(ctrl[c]);
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pend <= 0;
    end else if (memEndValid && memEndReady) begin
      pend <= 0;
    end else begin
      pend <= pend + ctrlSum - ((storeReqValid && storeReqReady) ? 1 : 0);
    end
  end

  // Not IDLE and not DONE leaves RUN or DRAIN
  storeInRun: assert property (@(posedge clk) disable iff (!rstN)
    storeReqValid |-> !memStartReady && !memEndValid)
    else $error("store request outside RUN or DRAIN");

  endAfterStores: assert property (@(posedge clk) disable iff (!rstN)
    $rose(memEndValid) |-> (pend == 0))
    else $error("memEndValid rose with %0d stores pending", pend);

  readReturn: assert property (@(posedge clk) disable iff (!rstN)
    (loadAddrValid && loadAddrReady) |=> loadDataValid)
    else $error("RAM read data missing one cycle after the read");

  noStrayRead: assert property (@(posedge clk) disable iff (!rstN)
    !(loadAddrValid && loadAddrReady) |=> !loadDataValid)
    else $error("RAM read data without a read");

  for (genvar p = 0; p < NUM_LOADS; p++) begin : gLdHold
    ldHeld: assert property (@(posedge clk) disable iff (!rstN)
      (ldDataValid[p] && !ldDataReady[p]) |=> (ldDataValid[p] && $stable(ldData[p])))
      else $error("ldData on port %0d changed before ready", p);
  end

endmodule

bind memController memSysProperties #(
  .NUM_LOADS   (NUM_LOADS),
  .NUM_CONTROLS(NUM_CONTROLS)
) props (
  .clk          (clk),
  .rstN         (rstN),
  .memStartReady(memStartReady),
  .memEndValid  (memEndValid),
  .memEndReady  (memEndReady),
  .ctrl         (ctrl),
  .ctrlValid    (ctrlValid),
  .ctrlReady    (ctrlReady),
  .ldData       (ldData),
  .ldDataValid  (ldDataValid),
  .ldDataReady  (ldDataReady),
  .loadAddrValid(loadAddrValid),
  .loadAddrReady(loadAddrReady),
  .loadDataValid(loadDataValid),
  .storeReqValid(storeReqValid),
  .storeReqReady(storeReqReady)
);

//--- verif/memSysTb.sv
module memSysTb;
  import memPkg::*;

  localparam int NL = 2;
  localparam int NS = 2;
  localparam int NC = 1;

  logic              clk;
  logic              rstN;
  logic              memStartValid;
  logic              memStartReady;
  logic              memEndValid;
  logic              memEndReady;
  logic              ctrlEndValid;
  logic              ctrlEndReady;
  cntT  [NC-1:0]     ctrl;
  logic [NC-1:0]     ctrlValid;
  logic [NC-1:0]     ctrlReady;
  addrT [NL-1:0]     ldAddr;
  logic [NL-1:0]     ldAddrValid;
  logic [NL-1:0]     ldAddrReady;
  dataT [NL-1:0]     ldData;
  logic [NL-1:0]     ldDataValid;
  logic [NL-1:0]     ldDataReady;
  addrT [NS-1:0]     stAddr;
  logic [NS-1:0]     stAddrValid;
  logic [NS-1:0]     stAddrReady;
  dataT [NS-1:0]     stData;
  logic [NS-1:0]     stDataValid;
  logic [NS-1:0]     stDataReady;

  // Case table read from the data file
  string cName[$];
  string cOp[$];
  int    cPort[$];
  addrT  cAddr[$];
  dataT  cData[$];

  // Reference model
  dataT  shadow [2 ** ADDR_W];
  int    pending;
  bit    started;
  bit    endTaken;
  addrT  addrQ [NL][$];
  dataT  expQ [NL][$];
  string nameQ [NL][$];
  logic [NL-1:0] addrTaken = '0;
  logic [NL-1:0] heldValid = '0;
  dataT [NL-1:0] heldData;
  logic [NL-1:0] stallOn = '0;
  int    accEdge [NL];
  logic [31:0] lfsr = 32'h4108;

  int    errors = 0;
  int    cycle = 0;
  int    limit = 100;
  string curName = "reset";
  string curOp = "none";

  clkGen #(.PERIOD(40)) clockSource (.clk(clk));

  memSys #(
    .NUM_LOADS   (NL),
    .NUM_STORES  (NS),
    .NUM_CONTROLS(NC),
    .INFLIGHT    (4)
  ) u_dut (.*);

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int loadsOutstanding();
    int n;
    n = 0;
    for (int p = 0; p < NL; p++) begin
      n += expQ[p].size();
    end
    return n;
  endfunction

  task automatic reportFail(input string test, input string what, input logic [31:0] exp,
                            input logic [31:0] act);
    $display("Fail %s %s: expected %h, actual %h", test, what, exp, act);
    errors++;
  endtask

  task automatic reportError(input string msg);
    $display("Error in test %s: %s", curName, msg);
    errors++;
  endtask

  task automatic readCases();
    int    fd;
    int    n;
    int    port;
    string line;
    string name;
    string op;
    logic [31:0] addr;
    logic [31:0] data;
    fd = $fopen("verif/memSysCases.txt", "r");
    if (fd == 0) begin
      reportError("cannot open verif/memSysCases.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %s %d %h %h", name, op, port, addr, data);
        if (n == 5 && line.getc(0) != "#") begin
          cName.push_back(name);
          cOp.push_back(op);
          cPort.push_back(port);
          cAddr.push_back(addrT'(addr));
          cData.push_back(data);
        end
      end
      $fclose(fd);
    end
  endtask

  // Everything that must be quiet outside a session, expected all zero
  task automatic checkIdle(input string when);
    logic [31:0] act;
    act = 32'({memEndValid, ctrlEndReady, ctrlReady, stAddrReady, stDataReady,
               ldAddrReady, ldDataValid, u_dut.loadAddrValid, u_dut.storeReqValid});
    if (act != 0) begin
      reportFail(curName, {"inactive outputs ", when}, 32'h0, act);
    end
  endtask

  task automatic drainLoads();
    while (loadsOutstanding() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic endSession();
    @(negedge clk);
    if (memEndValid !== 1'b1) begin
      reportFail(curName, "memEndValid one cycle after last store", 32'h1, 32'(memEndValid));
    end
    @(posedge clk);
    #2;
    memEndReady = 1'b1;
    @(negedge clk);
    while (!memEndValid) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    memEndReady = 1'b0;
    started = 1'b0;
    endTaken = 1'b0;
    pending = 0;
  endtask

  task automatic startOp(input int port, input addrT addr, input dataT data);
    stAddr[port] = addr;
    stData[port] = data;
    stAddrValid[port] = 1'b1;
    stDataValid[port] = 1'b1;
    memStartValid = 1'b1;
    @(negedge clk);
    checkIdle("before memStart");
    while (!memStartReady) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    memStartValid = 1'b0;
    stAddrValid[port] = 1'b0;
    stDataValid[port] = 1'b0;
    started = 1'b1;
    endTaken = 1'b0;
    pending = 0;
  endtask

  task automatic ctrlOp(input int port, input dataT data);
    ctrl[port] = cntT'(data);
    ctrlValid[port] = 1'b1;
    @(negedge clk);
    while (!ctrlReady[port]) begin
      @(negedge clk);
    end
    // A running session takes no second memStart
    if (memStartReady) begin
      reportFail(curName, "memStartReady while running", 32'h0, 32'(memStartReady));
    end
    @(posedge clk);
    #2;
    ctrlValid[port] = 1'b0;
    pending += int'(cntT'(data));
  endtask

  task automatic storeOp(input int port, input addrT addr, input dataT data);
    stAddr[port] = addr;
    stData[port] = data;
    stAddrValid[port] = 1'b1;
    stDataValid[port] = 1'b1;
    if (started && pending > 0) begin
      @(negedge clk);
      while (!(stAddrReady[port] && stDataReady[port])) begin
        @(negedge clk);
      end
      if (memEndValid) begin
        reportError("memEndValid high while stores are still owed");
      end
      @(posedge clk);
      #2;
      stAddrValid[port] = 1'b0;
      stDataValid[port] = 1'b0;
      shadow[addr] = data;
      pending--;
      if (endTaken && pending == 0) begin
        endSession();
      end
    end else begin
      // Beyond the announced count, must never be taken
      repeat (4) begin
        @(negedge clk);
        if (stAddrReady[port] || stDataReady[port]) begin
          reportError($sformatf("store on port %0d accepted beyond the count", port));
        end
      end
      @(posedge clk);
      #2;
      stAddrValid[port] = 1'b0;
      stDataValid[port] = 1'b0;
    end
  endtask

  task automatic endOp();
    drainLoads();
    ctrlEndValid = 1'b1;
    @(negedge clk);
    while (!ctrlEndReady) begin
      @(negedge clk);
    end
    if (memEndValid) begin
      reportError("memEndValid high before ctrlEnd was taken");
    end
    @(posedge clk);
    #2;
    ctrlEndValid = 1'b0;
    endTaken = 1'b1;
    if (pending == 0) begin
      endSession();
    end else begin
      @(negedge clk);
      if (memEndValid) begin
        reportError($sformatf("memEndValid high with %0d stores pending", pending));
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic runCase(input int i);
    int port;
    port = cPort[i];
    curName = cName[i];
    curOp = cOp[i];
    case (cOp[i])
      "start": startOp(port, cAddr[i], cData[i]);
      "ctrl":  ctrlOp(port, cData[i]);
      "store": storeOp(port, cAddr[i], cData[i]);
      "load": begin
        addrQ[port].push_back(cAddr[i]);
        expQ[port].push_back(shadow[cAddr[i]]);
        nameQ[port].push_back(cName[i]);
      end
      "end":   endOp();
      "stall": begin
        drainLoads();
        stallOn[port] = (cData[i] != 0);
      end
      default: reportError({"unknown op ", cOp[i]});
    endcase
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle > limit) begin
      $display("Timeout: no progress after %0d cycles in test %s, op %s", cycle, curName,
               curOp);
      $display("%0d errors before the timeout", errors);
      $display("Test failures found");
      $finish;
    end
  end

  // Load port drivers, one word per port at a time
  always @(posedge clk) begin
    #2;
    if (rstN) begin
      for (int p = 0; p < NL; p++) begin
        if (addrTaken[p]) begin
          ldAddrValid[p] = 1'b0;
          addrTaken[p] = 1'b0;
        end
        if (!ldAddrValid[p] && addrQ[p].size() > 0) begin
          ldAddr[p] = addrQ[p].pop_front();
          ldAddrValid[p] = 1'b1;
        end
        if (stallOn[p]) begin
          lfsr = lfsrNext(lfsr);
          ldDataReady[p] = lfsr[0];
        end else begin
          ldDataReady[p] = 1'b1;
        end
      end
    end
  end

  // Load responses, sampled mid-cycle
  always @(negedge clk) begin
    dataT  expWord;
    string tname;
    if (rstN) begin
      for (int p = 0; p < NL; p++) begin
        if (ldAddrValid[p] && ldAddrReady[p]) begin
          addrTaken[p] = 1'b1;
          accEdge[p] = cycle + 1;
        end
        if (heldValid[p] && !ldDataValid[p]) begin
          reportError($sformatf("ldDataValid on port %0d dropped before ready", p));
        end else if (heldValid[p] && ldData[p] !== heldData[p]) begin
          reportFail(curName, $sformatf("held ldData port %0d", p), heldData[p], ldData[p]);
        end else if (ldDataValid[p] && !heldValid[p] && !stallOn[p]
                     && cycle != accEdge[p] + 2) begin
          reportFail(curName, $sformatf("load latency port %0d", p), accEdge[p] + 2, cycle);
        end
        if (ldDataValid[p] && ldDataReady[p]) begin
          if (expQ[p].size() == 0) begin
            reportError($sformatf("port %0d returned a word that was never asked for", p));
          end else begin
            expWord = expQ[p].pop_front();
            tname = nameQ[p].pop_front();
            if (ldData[p] !== expWord) begin
              reportFail(tname, $sformatf("ldData port %0d", p), expWord, ldData[p]);
            end
          end
        end
        heldValid[p] = ldDataValid[p] && !ldDataReady[p];
        heldData[p] = ldData[p];
      end
    end
  end

  initial begin
    rstN = 1'b0;
    memStartValid = 1'b0;
    memEndReady = 1'b0;
    ctrlEndValid = 1'b0;
    ctrl = '0;
    ctrlValid = '0;
    ldAddr = '0;
    ldAddrValid = '0;
    ldDataReady = '0;
    stAddr = '0;
    stAddrValid = '0;
    stData = '0;
    stDataValid = '0;
    started = 1'b0;
    endTaken = 1'b0;
    pending = 0;
    readCases();
    limit = 40 * cName.size() + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkIdle("during reset");
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;
    @(negedge clk);
    checkIdle("after reset");
    @(posedge clk);
    #2;
    for (int i = 0; i < cName.size(); i++) begin
      runCase(i);
    end
    curOp = "final drain";
    drainLoads();
    repeat (2) @(posedge clk);
    $display("Ran %0d case lines, %0d errors", cName.size(), errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- memSys.f
design/memPkg.sv
design/storeController.sv
design/readArbiter.sv
design/memController.sv
design/dualPortRam.sv
design/memSys.sv
verif/clkGen.sv
verif/memSysProperties.sv_properties.sv
verif/memSysTb.sv

//--- Makefile
# Verilator build and run for the memSys testbench
VERILATOR ?= verilator
TOP       ?= memSysTb
FILELIST  ?= memSys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/memSysCases.txt
# Columns: test name, op, port, address (hex), data word or store count (hex)
# Ops are start, ctrl, store, load, end and stall; unused fields are 0
storeLoad start 0 10 0badcafe
storeLoad ctrl 0 0 4
storeLoad store 0 10 11112222
storeLoad store 1 11 33334444
storeLoad store 0 20 55556666
storeLoad store 1 21 77778888
storeLoad load 0 10 0
storeLoad load 1 21 0
dualLoad load 0 11 0
dualLoad load 1 20 0
dualLoad load 0 20 0
dualLoad load 1 10 0
stallLoad stall 1 0 1
stallLoad load 1 11 0
stallLoad load 0 21 0
stallLoad load 1 10 0
stallLoad load 0 11 0
stallLoad load 1 20 0
stallLoad load 0 10 0
stallLoad stall 1 0 0
stallLoad end 0 0 0
endCount start 1 30 0badcafe
endCount ctrl 0 0 1
endCount store 0 30 aaaa0001
endCount store 1 31 aaaa0002
endCount end 0 0 0
drainEnd start 0 0 0
drainEnd ctrl 0 0 2
drainEnd end 0 0 0
drainEnd store 1 32 bbbb0001
drainEnd store 0 33 bbbb0002
drainEnd load 0 30 0
drainEnd load 1 33 0
drainEnd load 0 32 0
